//--- acortex_pkg.sv
// Shared definitions for the audio playback path
// Sample widths and stereo pair type
// PCM FIFO depth, pointer and fill level sizes
// DAC bit clock divider and frame length
// Serializer state encoding

`default_nettype none

package acortex_pkg;

  localparam int PCM_W = 16;                   // One channel sample

  typedef logic [PCM_W-1:0]   pcm_word_t;
  typedef logic [2*PCM_W-1:0] pcm_pair_t;      // Left in upper half

  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_ADDR_W = 4;
  localparam int FIFO_AFULL  = 12;             // Stream back-pressure level

  typedef logic [FIFO_ADDR_W:0] fifo_cnt_t;

  // Bit clock toggles every BCLK_HALF clocks
  localparam int BCLK_HALF  = 2;
  localparam int BCLK_CNT_W = $clog2(BCLK_HALF);

  localparam int FRAME_BITS = 32;              // Left then right
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

  typedef enum logic [1:0]
  {
    SER_IDLE,
    SER_LEFT,
    SER_RIGHT
  } ser_state_t;

endpackage

`default_nettype wire

//--- pcm_fifo_if.sv
// Stereo PCM FIFO connection
// Write side from the sample packer, read side to the DAC serializer

`timescale 1ns/1ns
`default_nettype none

interface pcm_fifo_if import acortex_pkg::*; ();

  logic      wr_en;      // One-cycle write strobe
  pcm_pair_t wr_data;
  logic      afull;
  logic      rd_en;      // One-cycle pop strobe
  pcm_pair_t rd_data;    // Oldest sample while not empty
  logic      empty;

  modport producer
  (
    output wr_en,
    output wr_data,
    input  afull
  );

  modport buffer
  (
    input  wr_en,
    input  wr_data,
    input  rd_en,
    output afull,
    output rd_data,
    output empty
  );

  modport consumer (output rd_en, input rd_data, input empty);

endinterface

`default_nettype wire

//--- wav_sample_pack.sv
// Stream word acceptance with valid/ready
// Left/right pairing of 16-bit words into stereo samples
// Ready follows the FIFO almost-full flag

`timescale 1ns/1ns
`default_nettype none

module wav_sample_pack import acortex_pkg::*;
(
  input  logic             acortex_clk_ir,
  input  logic             acortex_rst_il,
  input  pcm_word_t        st_data,
  input  logic             st_valid,
  input  logic             st_sop,
  output logic             st_ready,
  pcm_fifo_if.producer     fifo
);

  logic      phase_right;   // Next word goes to the right channel
  pcm_word_t left_q;
  logic      accept;
  logic      left_word;

  assign st_ready  = ~fifo.afull;
  assign accept    = st_valid & st_ready;

  // Start of packet always restarts the pair
  assign left_word = st_sop | ~phase_right;

  always_ff @(posedge acortex_clk_ir or negedge acortex_rst_il)
  begin
    if (!acortex_rst_il)
    begin
      phase_right <= 1'b0;
      fifo.wr_en  <= 1'b0;
    end
    else
    begin
      fifo.wr_en <= 1'b0;
      if (accept)
      begin
        if (left_word)
          phase_right <= 1'b1;
        else
        begin
          phase_right <= 1'b0;
          fifo.wr_en  <= 1'b1;    // Pair complete
        end
      end
    end
  end

  // Sample payload
  always_ff @(posedge acortex_clk_ir)
  begin
    if (accept)
    begin
      if (left_word)
        left_q <= st_data;
      else
        fifo.wr_data <= {left_q, st_data};
    end
  end

endmodule

`default_nettype wire

//--- pcm_fifo.sv
// Stereo PCM sample FIFO
// Circular buffer with read and write pointers and a fill count
// Empty and full from the count, registered almost-full for back-pressure

`timescale 1ns/1ns
`default_nettype none

module pcm_fifo import acortex_pkg::*;
(
  input  logic       acortex_clk_ir,
  input  logic       acortex_rst_il,
  pcm_fifo_if.buffer fifo
);

  pcm_pair_t              mem [FIFO_DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  fifo_cnt_t              count;
  logic                   full;
  logic                   do_wr;
  logic                   do_rd;

  assign full       = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign fifo.empty = (count == '0);

  // Strobes are qualified so the pointers never pass each other
  assign do_wr = fifo.wr_en & ~full;
  assign do_rd = fifo.rd_en & ~fifo.empty;

  assign fifo.rd_data = mem[rd_ptr];   // Head of queue, no read latency

  always_ff @(posedge acortex_clk_ir)
  begin
    if (do_wr)
      mem[wr_ptr] <= fifo.wr_data;
  end

  always_ff @(posedge acortex_clk_ir or negedge acortex_rst_il)
  begin
    if (!acortex_rst_il)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      fifo.afull <= 1'b0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;

      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // Idle or push and pop together
      endcase

      // Lags the count by one cycle
      fifo.afull <= (count >= fifo_cnt_t'(FIFO_AFULL));
    end
  end

endmodule

`default_nettype wire

//--- dac_serializer.sv
// DAC bit clock generation
// Serial output of stereo frames, left then right, MSB first
// Pops one FIFO sample per frame, back-to-back while samples remain

`timescale 1ns/1ns
`default_nettype none

module dac_serializer import acortex_pkg::*;
(
  input  logic         acortex_clk_ir,
  input  logic         acortex_rst_il,
  pcm_fifo_if.consumer fifo,
  output logic         aud_bclk,
  output logic         aud_dac_lrc,
  output logic         aud_dac_dat
);

  ser_state_t            state;
  logic [BCLK_CNT_W-1:0] div_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;    // Index of the bit on the line
  pcm_pair_t             shift_q;
  logic                  tick;
  logic                  fall;
  logic                  last_bit;
  logic                  load;

  assign tick     = (div_cnt == BCLK_CNT_W'(BCLK_HALF - 1));
  assign fall     = tick & aud_bclk;   // Bit clock about to fall
  assign last_bit = (state != SER_IDLE) & (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

  // New frame from idle or straight after the last bit
  assign load        = fall & ~fifo.empty & ((state == SER_IDLE) | last_bit);
  assign fifo.rd_en  = load;

  always_ff @(posedge acortex_clk_ir or negedge acortex_rst_il)
  begin
    if (!acortex_rst_il)
    begin
      div_cnt  <= '0;
      aud_bclk <= 1'b0;
    end
    else if (tick)
    begin
      div_cnt  <= '0;
      aud_bclk <= ~aud_bclk;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge acortex_clk_ir or negedge acortex_rst_il)
  begin
    if (!acortex_rst_il)
    begin
      state       <= SER_IDLE;
      bit_cnt     <= '0;
      aud_dac_lrc <= 1'b1;
      aud_dac_dat <= 1'b0;
    end
    else if (fall)
    begin
      if (load)
      begin
        state       <= SER_LEFT;
        bit_cnt     <= '0;
        aud_dac_lrc <= 1'b0;                         // Frame start
        aud_dac_dat <= fifo.rd_data[FRAME_BITS-1];
      end
      else if (last_bit)
      begin
        state       <= SER_IDLE;                     // FIFO ran dry
        aud_dac_lrc <= 1'b1;
        aud_dac_dat <= 1'b0;
      end
      else if (state != SER_IDLE)
      begin
        bit_cnt     <= bit_cnt + 1'b1;
        aud_dac_dat <= shift_q[FRAME_BITS-1];
        if (bit_cnt == BIT_CNT_W'(PCM_W - 1))
        begin
          state       <= SER_RIGHT;
          aud_dac_lrc <= 1'b1;                       // Right MSB next
        end
      end
    end
  end

  // Bits still to send, top bit is the next one out
  always_ff @(posedge acortex_clk_ir)
  begin
    if (load)
      shift_q <= {fifo.rd_data[FRAME_BITS-2:0], 1'b0};
    else if (fall && state != SER_IDLE)
      shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
  end

endmodule

`default_nettype wire

//--- acortex_top.sv
// Audio Cortex playback path top level
// Stream input to sample packer, PCM FIFO and DAC serializer
// Plain ports, internal blocks joined by the FIFO interface

`timescale 1ns/1ns
`default_nettype none

module acortex_top import acortex_pkg::*;
(
  input  logic      acortex_clk_ir,
  input  logic      acortex_rst_il,

  input  pcm_word_t st_data,
  input  logic      st_valid,
  input  logic      st_sop,
  output logic      st_ready,

  output logic      aud_bclk,
  output logic      aud_dac_lrc,
  output logic      aud_dac_dat
);

  pcm_fifo_if pcm_if ();

  wav_sample_pack pack_i
  (
    .acortex_clk_ir (acortex_clk_ir),
    .acortex_rst_il (acortex_rst_il),
    .st_data        (st_data),
    .st_valid       (st_valid),
    .st_sop         (st_sop),
    .st_ready       (st_ready),
    .fifo           (pcm_if.producer)
  );

  pcm_fifo fifo_i
  (
    .acortex_clk_ir (acortex_clk_ir),
    .acortex_rst_il (acortex_rst_il),
    .fifo           (pcm_if.buffer)
  );

  dac_serializer ser_i
  (
    .acortex_clk_ir (acortex_clk_ir),
    .acortex_rst_il (acortex_rst_il),
    .fifo           (pcm_if.consumer),
    .aud_bclk       (aud_bclk),
    .aud_dac_lrc    (aud_dac_lrc),
    .aud_dac_dat    (aud_dac_dat)
  );

endmodule

`default_nettype wire

//--- tb_acortex_checker.sv
// Assertions on the stereo PCM FIFO
// No write when full, no pop when empty, almost-full lags the count by one cycle

`timescale 1ns/1ns
`default_nettype none

module tb_acortex_checker import acortex_pkg::*;
(
  input logic      acortex_clk_ir,
  input logic      acortex_rst_il,
  input logic      wr_en,
  input logic      rd_en,
  input logic      empty,
  input logic      afull,
  input fifo_cnt_t count
);

  // Producer must be held off by almost-full
  wr_not_full_a: assert property (@(posedge acortex_clk_ir) disable iff (!acortex_rst_il)
    !(wr_en && count == fifo_cnt_t'(FIFO_DEPTH)))
    else $error("FIFO write strobe while full");

  rd_not_empty_a: assert property (@(posedge acortex_clk_ir) disable iff (!acortex_rst_il)
    !(rd_en && empty))
    else $error("FIFO read strobe while empty");

  afull_lag_a: assert property (@(posedge acortex_clk_ir) disable iff (!acortex_rst_il)
    afull == $past(count >= fifo_cnt_t'(FIFO_AFULL)))
    else $error("Almost-full does not follow the fill level");

endmodule

`default_nettype wire

//--- tb_acortex.sv
// Testbench for the audio playback path
// Random stream stimulus from a fixed seed, left/right pairing model
// Frame monitor on the DAC serial output, compare tasks, watchdog

`timescale 1ns/1ns
`default_nettype none

module tb_acortex import acortex_pkg::*; ();

  localparam int NUM_WORDS      = 200;
  localparam int CLK_HALF_NS    = 4;
  localparam int FRAME_CYCLES   = FRAME_BITS * 2 * BCLK_HALF;
  localparam int TIMEOUT_NS     = NUM_WORDS * FRAME_CYCLES * 2 * CLK_HALF_NS * 2;

  logic      acortex_clk_ir;
  logic      acortex_rst_il;
  pcm_word_t st_data;
  logic      st_valid;
  logic      st_sop;
  logic      st_ready;
  logic      aud_bclk;
  logic      aud_dac_lrc;
  logic      aud_dac_dat;

  integer    seed = 32'h9185e009;
  logic      model_right;          // Next accepted word is a right word
  pcm_word_t model_left;
  pcm_pair_t exp_q [$];
  int        accepted      = 0;
  int        pair_count    = 0;
  int        frames_started = 0;
  int        frames_done   = 0;
  int        value_errors  = 0;
  int        other_errors  = 0;
  logic      saw_backpressure = 1'b0;

  acortex_top dut_i
  (
    .acortex_clk_ir (acortex_clk_ir),
    .acortex_rst_il (acortex_rst_il),
    .st_data        (st_data),
    .st_valid       (st_valid),
    .st_sop         (st_sop),
    .st_ready       (st_ready),
    .aud_bclk       (aud_bclk),
    .aud_dac_lrc    (aud_dac_lrc),
    .aud_dac_dat    (aud_dac_dat)
  );

  bind pcm_fifo tb_acortex_checker fifo_chk_i
  (
    .acortex_clk_ir (acortex_clk_ir),
    .acortex_rst_il (acortex_rst_il),
    .wr_en          (fifo.wr_en),
    .rd_en          (fifo.rd_en),
    .empty          (fifo.empty),
    .afull          (fifo.afull),
    .count          (count)
  );

  always #(CLK_HALF_NS) acortex_clk_ir = ~acortex_clk_ir;

  task automatic compare_word(input pcm_word_t exp, input pcm_word_t act, input string chan);
    if (exp !== act)
    begin
      value_errors++;
      $display("** Error at %0t: %s word expected %h, got %h", $time, chan, exp, act);
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    if (exp != act)
    begin
      value_errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, what, exp, act);
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (exp !== act)
    begin
      value_errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, what, exp, act);
    end
  endtask

  // Acceptance seen half a cycle ahead, inputs are stable here
  always @(negedge acortex_clk_ir)
  begin
    if (acortex_rst_il)
    begin
      if (!st_ready)
        saw_backpressure = 1'b1;
      if (st_valid && st_ready)
      begin
        accepted++;
        if (st_sop || !model_right)
        begin
          model_left  = st_data;   // Unpaired left word is dropped on sop
          model_right = 1'b1;
        end
        else
        begin
          exp_q.push_back({model_left, st_data});
          pair_count++;
          model_right = 1'b0;
        end
      end
    end
  end

  // Frame monitor, one stereo sample per lrc fall
  always
  begin
    pcm_pair_t frame;
    pcm_pair_t exp;
    @(negedge aud_dac_lrc);
    frames_started++;
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      @(posedge aud_bclk);
      frame[FRAME_BITS-1-i] = aud_dac_dat;    // MSB first
    end
    if (exp_q.size() == 0)
    begin
      other_errors++;
      $display("A frame came out at %0t with no sample left in the model", $time);
    end
    else
    begin
      exp = exp_q.pop_front();
      compare_word(exp[2*PCM_W-1:PCM_W], frame[2*PCM_W-1:PCM_W], "left");
      compare_word(exp[PCM_W-1:0], frame[PCM_W-1:0], "right");
    end
    frames_done++;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d frames were seen", frames_done, pair_count);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] rnd;
    acortex_clk_ir = 1'b0;
    acortex_rst_il = 1'b0;
    st_data        = '0;
    st_valid       = 1'b0;
    st_sop         = 1'b0;
    model_right    = 1'b0;
    model_left     = '0;

    repeat (3) @(posedge acortex_clk_ir);
    acortex_rst_il <= 1'b1;
    @(negedge acortex_clk_ir);
    compare_bit("st_ready after reset", 1'b1, st_ready);
    compare_bit("aud_bclk after reset", 1'b0, aud_bclk);
    compare_bit("aud_dac_lrc after reset", 1'b1, aud_dac_lrc);
    compare_bit("aud_dac_dat after reset", 1'b0, aud_dac_dat);

    @(posedge acortex_clk_ir);
    while (accepted < NUM_WORDS)
    begin
      rnd = $random(seed);
      st_valid <= rnd[0];
      rnd = $random(seed);
      st_sop   <= (rnd % 20) == 0;    // About one word in 20
      rnd = $random(seed);
      st_data  <= rnd[PCM_W-1:0];
      @(posedge acortex_clk_ir);
    end
    st_valid <= 1'b0;
    st_sop   <= 1'b0;

    wait (frames_done == pair_count);
    // Idle time to catch any extra frame
    repeat (2 * FRAME_CYCLES) @(negedge acortex_clk_ir);

    compare_count("frames started", pair_count, frames_started);
    compare_count("frames checked", pair_count, frames_done);
    compare_bit("aud_dac_lrc when idle", 1'b1, aud_dac_lrc);
    if (!saw_backpressure)
    begin
      other_errors++;
      $display("st_ready never went low during the stream");
    end

    $display("Errors: %0d wrong values, %0d other failures, %0d frames",
             value_errors, other_errors, frames_done);
    if (value_errors == 0 && other_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
acortex_pkg.sv
pcm_fifo_if.sv
wav_sample_pack.sv
pcm_fifo.sv
dac_serializer.sv
acortex_top.sv
tb_acortex_checker.sv
tb_acortex.sv
